// ==== all.f ====
xt_periph_pkg.sv
xt_bus_if.sv
xt_addr_decode.sv
xt_sync_mem.sv
xt_memory_map.sv
xt_sys_ctrl_port.sv
xt_readback.sv
xt_peripherals.sv
tb_clock_gen.sv
tb_xt_peripherals.sv

// ==== tb_clock_gen.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset. 20 ns clock, reset high for the first two
// rising edges and released on a falling edge.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clock_o,
    output logic reset_o
);

    initial begin
        clock_o = 1'b0;
        forever #10 clock_o = ~clock_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (2) @(posedge clock_o);
        @(negedge clock_o);
        reset_o = 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb_xt_peripherals.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the XT peripheral glue. Reads bus operations and expected
// bytes from xt_stim.txt, runs them against the DUT and checks the outputs.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_xt_peripherals import xt_periph_pkg::*; ();

    logic        clock;
    logic        reset;
    addr_t       address;
    byte_t       wdata;
    logic        io_read_n;
    logic        io_write_n;
    logic        memory_read_n;
    logic        memory_write_n;
    logic        address_enable_n;
    logic        enable_cga;
    byte_t       keycode;
    byte_t       port_c;
    logic        ioctl_download;
    logic        ioctl_wr;
    logic [24:0] ioctl_addr;
    byte_t       ioctl_data;
    byte_t       bus_out;
    logic        bus_drive;
    logic        dma_cs_n;
    logic        dma_page_cs_n;
    logic        speaker_gate;
    logic        speaker_data;
    logic        kbd_reset_n;

    // Reference state kept by the testbench
    logic        cga_on;
    byte_t       port_b_model;
    int          errors;
    int          checks;
    int          num_ops;
    bit          stim_loaded;

    logic [7:0]  op_q[$];
    addr_t       addr_q[$];
    byte_t       data_q[$];
    byte_t       exp_q[$];

    tb_clock_gen u_clock_gen (
        .clock_o (clock),
        .reset_o (reset)
    );

    xt_peripherals dut (
        .clock                    (clock),
        .reset                    (reset),
        .address_i                (address),
        .data_i                   (wdata),
        .io_read_n_i              (io_read_n),
        .io_write_n_i             (io_write_n),
        .memory_read_n_i          (memory_read_n),
        .memory_write_n_i         (memory_write_n),
        .address_enable_n_i       (address_enable_n),
        .enable_cga_i             (enable_cga),
        .keycode_i                (keycode),
        .port_c_i                 (port_c),
        .ioctl_download_i         (ioctl_download),
        .ioctl_wr_i               (ioctl_wr),
        .ioctl_addr_i             (ioctl_addr),
        .ioctl_data_i             (ioctl_data),
        .data_bus_out_o           (bus_out),
        .data_bus_drive_o         (bus_drive),
        .dma_chip_select_n_o      (dma_cs_n),
        .dma_page_chip_select_n_o (dma_page_cs_n),
        .speaker_gate_o           (speaker_gate),
        .speaker_data_o           (speaker_data),
        .kbd_reset_n_o            (kbd_reset_n)
    );

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    function automatic bit is_op_char(input int c);
        return c == "W" || c == "R" || c == "O" || c == "I" || c == "L" || c == "K"
               || c == "C";
    endfunction

    function automatic bit is_space(input int c);
        return c == " " || c == "\t" || c == "\n" || c == "\r";
    endfunction

    // Which reads should put a byte on the chipset bus
    function automatic logic drive_expected(input logic is_io, input addr_t addr);
        if (is_io) begin
            return addr[9:5] == 5'b00011;
        end
        return addr[19:18] == 2'b00 || addr[19:16] == 4'hF
               || (cga_on && addr[19:15] == 5'b10111);
    endfunction

    task automatic load_stimulus(output bit opened);
        int    fd;
        int    c;
        int    n;
        addr_t a;
        byte_t d;
        byte_t e;
        fd = $fopen("xt_stim.txt", "r");
        opened = (fd != 0);
        if (opened) begin
            c = $fgetc(fd);
            while (c != -1) begin
                if (c == "#") begin
                    while (c != "\n" && c != -1) begin
                        c = $fgetc(fd);
                    end
                end else if (is_op_char(c)) begin
                    n = $fscanf(fd, "%h %h %h", a, d, e);
                    if (n == 3) begin
                        op_q.push_back(8'(c));
                        addr_q.push_back(a);
                        data_q.push_back(d);
                        exp_q.push_back(e);
                    end else begin
                        errors++;
                        $display("Stimulus entry for operation %c is incomplete", 8'(c));
                    end
                end else if (!is_space(c)) begin
                    errors++;
                    $display("Stimulus file holds an unknown operation %c", 8'(c));
                end
                if (c != -1) begin
                    c = $fgetc(fd);
                end
            end
            $fclose(fd);
            num_ops = op_q.size();
        end
    endtask

    task automatic check_dma_selects(input addr_t addr);
        check_bit("dma_chip_select_n_o", dma_cs_n, addr[9:5] != 5'b00000);
        check_bit("dma_page_chip_select_n_o", dma_page_cs_n, addr[9:5] != 5'b00100);
    endtask

    task automatic check_port_b_outputs();
        check_bit("speaker_gate_o", speaker_gate, port_b_model[0]);
        check_bit("speaker_data_o", speaker_data, port_b_model[1]);
        check_bit("kbd_reset_n_o", kbd_reset_n, port_b_model[6]);
    endtask

    // Strobe held low for two clocks, starting on a falling edge
    task automatic bus_write(input logic is_io, input addr_t addr, input byte_t data);
        address = addr;
        wdata = data;
        address_enable_n = 1'b0;
        if (is_io) begin
            io_write_n = 1'b0;
        end else begin
            memory_write_n = 1'b0;
        end
        @(negedge clock);
        if (is_io) begin
            check_dma_selects(addr);
        end
        @(negedge clock);
        io_write_n = 1'b1;
        memory_write_n = 1'b1;
        address_enable_n = 1'b1;
        if (is_io && addr[9:5] == 5'b00011 && addr[1:0] == 2'b01) begin
            port_b_model = data;
        end
        if (is_io) begin
            check_port_b_outputs();
        end
    endtask

    task automatic bus_read(input logic is_io, input addr_t addr, input byte_t switches,
                            input byte_t exp);
        address = addr;
        address_enable_n = 1'b0;
        if (is_io) begin
            port_c = switches;
            io_read_n = 1'b0;
        end else begin
            memory_read_n = 1'b0;
        end
        // Second strobe cycle, memory data is valid here
        @(negedge clock);
        check_bit("data_bus_drive_o", bus_drive, drive_expected(is_io, addr));
        check_byte("data_bus_out_o", bus_out, exp);
        if (is_io) begin
            check_dma_selects(addr);
        end
        @(negedge clock);
        io_read_n = 1'b1;
        memory_read_n = 1'b1;
        address_enable_n = 1'b1;
    endtask

    task automatic download_byte(input addr_t addr, input byte_t data);
        ioctl_download = 1'b1;
        ioctl_wr = 1'b1;
        ioctl_addr = {5'b0, addr};
        ioctl_data = data;
        @(negedge clock);
        ioctl_wr = 1'b0;
        ioctl_download = 1'b0;
        @(negedge clock);
    endtask

    task automatic run_op(input logic [7:0] op, input addr_t a, input byte_t d,
                          input byte_t e);
        case (op)
            "W": bus_write(1'b0, a, d);
            "O": bus_write(1'b1, a, d);
            "R": bus_read(1'b0, a, d, e);
            "I": bus_read(1'b1, a, d, e);
            "L": download_byte(a, d);
            "K": begin
                keycode = d;
                repeat (3) @(negedge clock);
            end
            "C": begin
                enable_cga = d[0];
                cga_on = d[0];
                @(negedge clock);
            end
            default: begin
                errors++;
                $display("Operation %c cannot be run", op);
            end
        endcase
    endtask

    initial begin : watchdog
        wait (stim_loaded);
        #(num_ops * 200 + 1000);
        $display("Timeout: the stimulus did not finish in %0d ns", num_ops * 200 + 1000);
        $display("Test failed");
        $finish;
    end

    initial begin : main
        bit opened;
        address = '0;
        wdata = '0;
        io_read_n = 1'b1;
        io_write_n = 1'b1;
        memory_read_n = 1'b1;
        memory_write_n = 1'b1;
        address_enable_n = 1'b1;
        enable_cga = 1'b0;
        keycode = '0;
        port_c = '0;
        ioctl_download = 1'b0;
        ioctl_wr = 1'b0;
        ioctl_addr = '0;
        ioctl_data = '0;
        cga_on = 1'b0;
        port_b_model = '0;
        errors = 0;
        checks = 0;
        load_stimulus(opened);
        if (!opened) begin
            $display("Could not open the stimulus file xt_stim.txt");
            $display("Test failed");
            $finish;
        end else begin
            stim_loaded = 1'b1;
            wait (reset === 1'b0);
            @(negedge clock);
            // State straight after reset
            check_bit("data_bus_drive_o", bus_drive, 1'b0);
            check_bit("dma_chip_select_n_o", dma_cs_n, 1'b1);
            check_bit("dma_page_chip_select_n_o", dma_page_cs_n, 1'b1);
            check_port_b_outputs();
            for (int i = 0; i < num_ops; i++) begin
                run_op(op_q[i], addr_q[i], data_q[i], exp_q[i]);
            end
            @(negedge clock);
            $display("Checks: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== xt_addr_decode.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address decoder. Produces address-only I/O and memory selects for the
// internal blocks and the active-low DMA selects for the external chips.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module xt_addr_decode import xt_periph_pkg::*; (
    xt_bus_if.sink      bus_i,
    input  wire logic   enable_cga_i,
    output io_sel_t     io_sel_o,
    output mem_sel_t    mem_sel_o,
    output logic        dma_chip_select_n_o,
    output logic        dma_page_chip_select_n_o
);

    logic       io_page0;
    logic [2:0] io_group;

    // Only the first 256 ports are decoded here
    assign io_page0 = bus_i.aen && (bus_i.address[9:8] == 2'b00);
    assign io_group = bus_i.address[7:5];

    always_comb begin
        io_sel_o = '0;
        if (io_page0) begin
            io_sel_o.dma      = (io_group == IO_GROUP_DMA);
            io_sel_o.dma_page = (io_group == IO_GROUP_DMA_PAGE);
            io_sel_o.ppi      = (io_group == IO_GROUP_PPI);
        end
    end

    // Memory windows from the upper address bits
    always_comb begin
        mem_sel_o.ram  = (bus_i.address[ADDR_W-1 -: 2] == RAM_BASE_TAG);
        // Video RAM spans 32 KB, so address bit 14 is not compared
        mem_sel_o.vram = enable_cga_i
                         && (bus_i.address[ADDR_W-1 -: 5] == VRAM_BASE_TAG[5:1]);
        mem_sel_o.rom  = (bus_i.address[ADDR_W-1 -: 4] == ROM_BASE_TAG);
    end

    // External chips take their selects active low
    assign dma_chip_select_n_o      = ~io_sel_o.dma;
    assign dma_page_chip_select_n_o = ~io_sel_o.dma_page;

endmodule

`default_nettype wire

// ==== xt_bus_if.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU bus request as seen inside the peripheral block. The top level
// fills it from the pins, all other blocks read it through the sink side.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface xt_bus_if import xt_periph_pkg::*; ();

    addr_t address;
    byte_t wdata;

    // Strobes, active high
    logic  io_rd;
    logic  io_wr;
    logic  mem_rd;
    logic  mem_wr;

    // High while the CPU owns the bus
    logic  aen;

    modport source (
        output address,
        output wdata,
        output io_rd,
        output io_wr,
        output mem_rd,
        output mem_wr,
        output aen
    );

    modport sink (
        input  address,
        input  wdata,
        input  io_rd,
        input  io_wr,
        input  mem_rd,
        input  mem_wr,
        input  aen
    );

endinterface

`default_nettype wire

// ==== xt_memory_map.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// System RAM, colour video RAM and BIOS ROM on the CPU bus. The ROM is
// written only through the download port, never by the CPU.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module xt_memory_map import xt_periph_pkg::*; (
    input  wire logic           clock,
    xt_bus_if.sink              bus_i,
    input  wire mem_sel_t       mem_sel_i,
    input  wire logic           ioctl_download_i,
    input  wire logic           ioctl_wr_i,
    input  wire logic [24:0]    ioctl_addr_i,
    input  wire byte_t          ioctl_data_i,
    output byte_t               ram_rdata_o,
    output byte_t               vram_rdata_o,
    output byte_t               rom_rdata_o
);

    logic              mem_access;
    logic              ram_en;
    logic              vram_en;
    logic              rom_en;
    logic              rom_we;
    logic [ROM_AW-1:0] rom_addr;

    assign mem_access = bus_i.mem_rd || bus_i.mem_wr;

    assign ram_en  = mem_sel_i.ram && mem_access;
    assign vram_en = mem_sel_i.vram && mem_access;

    // Download port owns the ROM while a download runs
    always_comb begin
        if (ioctl_download_i) begin
            rom_en   = ioctl_wr_i;
            rom_we   = ioctl_wr_i;
            rom_addr = ioctl_addr_i[ROM_AW-1:0];
        end else begin
            rom_en   = mem_sel_i.rom && bus_i.mem_rd;
            rom_we   = 1'b0;
            rom_addr = bus_i.address[ROM_AW-1:0];
        end
    end

    xt_sync_mem #(.AW(RAM_AW)) u_ram (
        .clock   (clock),
        .en_i    (ram_en),
        .we_i    (bus_i.mem_wr),
        .addr_i  (bus_i.address[RAM_AW-1:0]),
        .wdata_i (bus_i.wdata),
        .rdata_o (ram_rdata_o)
    );

    xt_sync_mem #(.AW(VRAM_AW)) u_vram (
        .clock   (clock),
        .en_i    (vram_en),
        .we_i    (bus_i.mem_wr),
        .addr_i  (bus_i.address[VRAM_AW-1:0]),
        .wdata_i (bus_i.wdata),
        .rdata_o (vram_rdata_o)
    );

    // Write data only ever comes from the download port
    xt_sync_mem #(.AW(ROM_AW)) u_rom (
        .clock   (clock),
        .en_i    (rom_en),
        .we_i    (rom_we),
        .addr_i  (rom_addr),
        .wdata_i (ioctl_data_i),
        .rdata_o (rom_rdata_o)
    );

endmodule

`default_nettype wire

// ==== xt_periph_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, address map tags, I/O group numbers and port B bit
// positions for the XT peripheral glue. Modules import it by wildcard.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package xt_periph_pkg;

    // CPU bus
    localparam int ADDR_W = 20;
    localparam int DATA_W = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] byte_t;

    // Memory array address widths
    localparam int RAM_AW  = 18;    // 256 KB
    localparam int VRAM_AW = 15;    // 32 KB
    localparam int ROM_AW  = 16;    // 64 KB

    // Upper address bits of each memory window
    localparam logic [1:0] RAM_BASE_TAG  = 2'b00;       // 00000 - 3FFFF
    localparam logic [5:0] VRAM_BASE_TAG = 6'b1011_10;  // B8000 - BFFFF
    localparam logic [3:0] ROM_BASE_TAG  = 4'b1111;     // F0000 - FFFFF

    // 32-byte groups in the first I/O page, index is address[7:5]
    localparam logic [2:0] IO_GROUP_DMA      = 3'd0;    // 0x00
    localparam logic [2:0] IO_GROUP_PPI      = 3'd3;    // 0x60
    localparam logic [2:0] IO_GROUP_DMA_PAGE = 3'd4;    // 0x80

    // System control port register offsets
    localparam logic [1:0] PORT_A_OFS = 2'd0;
    localparam logic [1:0] PORT_B_OFS = 2'd1;
    localparam logic [1:0] PORT_C_OFS = 2'd2;

    // Port B bits
    localparam int PB_TIMER_GATE_BIT   = 0;
    localparam int PB_SPEAKER_DATA_BIT = 1;
    localparam int PB_KBD_RESET_BIT    = 6;
    localparam int PB_CLEAR_KEY_BIT    = 7;

    typedef struct packed {
        logic dma;
        logic dma_page;
        logic ppi;
    } io_sel_t;

    typedef struct packed {
        logic ram;
        logic vram;
        logic rom;
    } mem_sel_t;

endpackage

`default_nettype wire

// ==== xt_peripherals.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top of the XT peripheral glue. Converts the active-low bus pins once and
// wires the decoder, memories, system control port and read-back mux.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module xt_peripherals import xt_periph_pkg::*; (
    input  wire logic           clock,
    input  wire logic           reset,
    // CPU bus
    input  wire addr_t          address_i,
    input  wire byte_t          data_i,
    input  wire logic           io_read_n_i,
    input  wire logic           io_write_n_i,
    input  wire logic           memory_read_n_i,
    input  wire logic           memory_write_n_i,
    input  wire logic           address_enable_n_i,
    input  wire logic           enable_cga_i,
    // Keyboard and switches
    input  wire byte_t          keycode_i,
    input  wire byte_t          port_c_i,
    // BIOS download
    input  wire logic           ioctl_download_i,
    input  wire logic           ioctl_wr_i,
    input  wire logic [24:0]    ioctl_addr_i,
    input  wire byte_t          ioctl_data_i,
    // Outputs
    output byte_t               data_bus_out_o,
    output logic                data_bus_drive_o,
    output logic                dma_chip_select_n_o,
    output logic                dma_page_chip_select_n_o,
    output logic                speaker_gate_o,
    output logic                speaker_data_o,
    output logic                kbd_reset_n_o
);

    io_sel_t  io_sel;
    mem_sel_t mem_sel;
    byte_t    ppi_rdata;
    byte_t    ram_rdata;
    byte_t    vram_rdata;
    byte_t    rom_rdata;

    xt_bus_if u_bus ();

    // Pins are active low, the internal bus is active high
    assign u_bus.address = address_i;
    assign u_bus.wdata   = data_i;
    assign u_bus.io_rd   = ~io_read_n_i;
    assign u_bus.io_wr   = ~io_write_n_i;
    assign u_bus.mem_rd  = ~memory_read_n_i;
    assign u_bus.mem_wr  = ~memory_write_n_i;
    assign u_bus.aen     = ~address_enable_n_i;

    xt_addr_decode u_addr_decode (
        .bus_i                    (u_bus.sink),
        .enable_cga_i             (enable_cga_i),
        .io_sel_o                 (io_sel),
        .mem_sel_o                (mem_sel),
        .dma_chip_select_n_o      (dma_chip_select_n_o),
        .dma_page_chip_select_n_o (dma_page_chip_select_n_o)
    );

    xt_memory_map u_memory_map (
        .clock            (clock),
        .bus_i            (u_bus.sink),
        .mem_sel_i        (mem_sel),
        .ioctl_download_i (ioctl_download_i),
        .ioctl_wr_i       (ioctl_wr_i),
        .ioctl_addr_i     (ioctl_addr_i),
        .ioctl_data_i     (ioctl_data_i),
        .ram_rdata_o      (ram_rdata),
        .vram_rdata_o     (vram_rdata),
        .rom_rdata_o      (rom_rdata)
    );

    xt_sys_ctrl_port u_sys_ctrl_port (
        .clock          (clock),
        .reset          (reset),
        .bus_i          (u_bus.sink),
        .ppi_sel_i      (io_sel.ppi),
        .keycode_i      (keycode_i),
        .port_c_i       (port_c_i),
        .rdata_o        (ppi_rdata),
        .speaker_gate_o (speaker_gate_o),
        .speaker_data_o (speaker_data_o),
        .kbd_reset_n_o  (kbd_reset_n_o)
    );

    xt_readback u_readback (
        .bus_i            (u_bus.sink),
        .io_sel_i         (io_sel),
        .mem_sel_i        (mem_sel),
        .ppi_rdata_i      (ppi_rdata),
        .ram_rdata_i      (ram_rdata),
        .vram_rdata_i     (vram_rdata),
        .rom_rdata_i      (rom_rdata),
        .data_bus_out_o   (data_bus_out_o),
        .data_bus_drive_o (data_bus_drive_o)
    );

endmodule

`default_nettype wire

// ==== xt_readback.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read-back multiplexer for the chipset data bus. Picks the first active
// source in priority order and drives zero when nothing is selected.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module xt_readback import xt_periph_pkg::*; (
    xt_bus_if.sink          bus_i,
    input  wire io_sel_t    io_sel_i,
    input  wire mem_sel_t   mem_sel_i,
    input  wire byte_t      ppi_rdata_i,
    input  wire byte_t      ram_rdata_i,
    input  wire byte_t      vram_rdata_i,
    input  wire byte_t      rom_rdata_i,
    output byte_t           data_bus_out_o,
    output logic            data_bus_drive_o
);

    // PPI first, then the memory windows
    always_comb begin
        data_bus_drive_o = 1'b1;
        if (io_sel_i.ppi && bus_i.io_rd) begin
            data_bus_out_o = ppi_rdata_i;
        end else if (mem_sel_i.vram && bus_i.mem_rd) begin
            data_bus_out_o = vram_rdata_i;
        end else if (mem_sel_i.rom && bus_i.mem_rd) begin
            data_bus_out_o = rom_rdata_i;
        end else if (mem_sel_i.ram && bus_i.mem_rd) begin
            data_bus_out_o = ram_rdata_i;
        end else begin
            data_bus_drive_o = 1'b0;
            data_bus_out_o   = '0;
        end
    end

endmodule

`default_nettype wire

// ==== xt_stim.txt ====
# Columns: op address data expected, all hex. W/R memory, O/I I/O, L download,
# K scan code, C CGA enable. On I, data is the port C switch value; R ignores it.
W 00010 3C 00
W 00011 A5 00
W 3FFFF 7E 00
W 12345 C9 00
R 00010 00 3C
R 00011 00 A5
R 3FFFF 00 7E
R 12345 00 C9
L 00000 EA 00
L 0FFF0 5B 00
L 01234 99 00
R F0000 00 EA
R FFFF0 00 5B
R F1234 00 99
W F1234 11 00
R F1234 00 99
C 00000 01 00
W B8000 41 00
W BB000 07 00
R B8000 00 41
R BB000 00 07
C 00000 00 00
R B8000 00 00
R 50000 00 00
O 00061 43 00
I 00061 00 43
I 00062 5A 5A
K 00000 3A 00
I 00060 00 3A
O 00061 80 00
I 00060 00 00
O 00061 00 00
I 00060 00 3A
I 00000 00 00
I 00080 00 00
O 00083 12 00
O 00003 55 00

// ==== xt_sync_mem.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-port synchronous byte memory with registered read data.
// A read during a write returns the old contents of the location.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module xt_sync_mem import xt_periph_pkg::*; #(
    parameter int AW = 16
) (
    input  wire logic           clock,
    input  wire logic           en_i,
    input  wire logic           we_i,
    input  wire logic [AW-1:0]  addr_i,
    input  wire byte_t          wdata_i,
    output byte_t               rdata_o
);

    localparam int DEPTH = 2 ** AW;

    byte_t mem [DEPTH];

    // Nonblocking write, so the read below still sees the old byte
    always_ff @(posedge clock) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end
            rdata_o <= mem[addr_i];
        end
    end

endmodule

`default_nettype wire

// ==== xt_sys_ctrl_port.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Keyboard/speaker system control port at I/O group 0x60. Port A is the
// synchronized scan code, port B the control register, port C the switches.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module xt_sys_ctrl_port import xt_periph_pkg::*; (
    input  wire logic   clock,
    input  wire logic   reset,
    xt_bus_if.sink      bus_i,
    input  wire logic   ppi_sel_i,
    input  wire byte_t  keycode_i,
    input  wire byte_t  port_c_i,
    output byte_t       rdata_o,
    output logic        speaker_gate_o,
    output logic        speaker_data_o,
    output logic        kbd_reset_n_o
);

    logic [1:0] reg_ofs;
    logic       port_b_wr;
    byte_t      port_b;
    byte_t      keycode_meta;
    byte_t      port_a;

    assign reg_ofs   = bus_i.address[1:0];
    assign port_b_wr = ppi_sel_i && bus_i.io_wr && (reg_ofs == PORT_B_OFS);

    // Port B control register
    always_ff @(posedge clock) begin
        if (reset) begin
            port_b <= '0;
        end else if (port_b_wr) begin
            port_b <= bus_i.wdata;
        end
    end

    // Two-flop synchronizer for the scan code
    always_ff @(posedge clock) begin
        if (reset) begin
            keycode_meta <= '0;
            port_a       <= '0;
        end else begin
            keycode_meta <= keycode_i;
            port_a       <= keycode_meta;
        end
    end

    always_comb begin
        case (reg_ofs)
            PORT_A_OFS: rdata_o = port_b[PB_CLEAR_KEY_BIT] ? '0 : port_a;
            PORT_B_OFS: rdata_o = port_b;
            PORT_C_OFS: rdata_o = port_c_i;
            default:    rdata_o = '0;
        endcase
    end

    assign speaker_gate_o = port_b[PB_TIMER_GATE_BIT];
    assign speaker_data_o = port_b[PB_SPEAKER_DATA_BIT];
    // Keyboard held in reset until software sets bit 6
    assign kbd_reset_n_o  = port_b[PB_KBD_RESET_BIT];

endmodule

`default_nettype wire
